// File: build.f
+incdir+sim
common/histPkg.sv
common/apbPkg.sv
common/binBusIf.sv
rtl/sampleFolder.sv
histBuilder/histBuilder.sv
histBuilder/peakFinder.sv
rtl/apbRegs.sv
rtl/histTop.sv
sim/histTb.sv

// File: common/apbPkg.sv
package apbPkg;

    // byte offset inside the register block
    typedef logic [7:0] apbAddrT;

    // samples collected per pass
    typedef logic [11:0] nSampT;

    // register map
    localparam apbAddrT REG_CTRL   = 8'h00;
    localparam apbAddrT REG_NSAMP  = 8'h04;
    localparam apbAddrT REG_STATUS = 8'h08;
    localparam apbAddrT REG_COARSE = 8'h0C;
    localparam apbAddrT REG_FINE   = 8'h10;
    localparam apbAddrT REG_RESULT = 8'h14;

    // pass length out of reset
    localparam nSampT nSampReset = 12'd64;

    // STATUS bits, busy in bit0
    typedef struct packed {
        logic done;
        logic busy;
    } statusT;

endpackage

// File: common/binBusIf.sv
interface binBusIf import histPkg::*; ();

    // one folded sample per cycle at most
    logic binValid;
    // coarse events always binned, fine only inside the window
    logic inWindow;
    binT binAddr;
    // pass the event belongs to
    phaseT phase;
    // builder still wants samples in this pass
    logic ready;

    modport folder (
        output binValid,
        output inWindow,
        output binAddr,
        output phase,
        input  ready
    );

    modport builder (
        input  binValid,
        input  inWindow,
        input  binAddr,
        input  phase,
        output ready
    );

endinterface

// File: common/histPkg.sv
package histPkg;

    // raw time-of-flight code from the TDC
    typedef logic [9:0] tsT;

    // index into either 16-bin histogram
    typedef logic [3:0] binT;

    // hits in one bin
    typedef logic [7:0] countT;

    // pass sequencing
    // builder state, also the tag on each folded event
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_COARSE,
        PH_SCAN_C,
        PH_FINE,
        PH_SCAN_F,
        PH_DONE
    } phaseT;

    // coarse bin = top four code bits
    localparam int coarseShift = 6;
    // fine window width in codes
    localparam int winSpan = 128;
    // 8-code fine bins
    localparam int fineShift = 3;
    // window opens this far below the coarse bin edge
    localparam int winLead = 32;
    // highest base that keeps the window inside the code range
    localparam int winMaxBase = 896;
    // middle of a fine bin
    localparam int fineHalf = 4;

endpackage

// File: histBuilder/histBuilder.sv
module histBuilder import histPkg::*, apbPkg::*; #(
    parameter int countWidth = 8
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  nSampT    nSamp,
    binBusIf.builder bus,
    input  binT      scanAddr,
    output countT    scanCount,
    input  logic     peakValid,
    output phaseT    phase
);

    // counters stop here
    localparam countT countMax = countT'((1 << countWidth) - 1);

    countT hist [16];
    // events absorbed in this pass
    nSampT absorbed;
    logic acquiring;
    logic lastHit;
    logic clearHist;
    logic [12:0] inFlight;

    assign acquiring = (phase == PH_COARSE) || (phase == PH_FINE);

    // absorbed plus the one still sitting in the folder register
    assign inFlight = {1'b0, absorbed} + 13'(bus.binValid);
    // drops right after the Nth handshake
    assign bus.ready = acquiring && (inFlight < {1'b0, nSamp});

    // Nth event of the pass arriving now
    assign lastHit = bus.binValid && (({1'b0, absorbed} + 13'd1) == {1'b0, nSamp});

    // fresh histogram at run start and before the fine pass
    assign clearHist = (start && (phase == PH_IDLE || phase == PH_DONE)) ||
                       (peakValid && phase == PH_SCAN_C);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_IDLE;
            absorbed <= '0;
        end else begin
            case (phase)
                PH_IDLE, PH_DONE: begin
                    // start while busy never reaches here
                    if (start) begin
                        phase <= PH_COARSE;
                        absorbed <= '0;
                    end
                end
                PH_COARSE, PH_FINE: begin
                    // out-of-window fine samples still count toward N
                    if (bus.binValid) begin
                        absorbed <= absorbed + 1'b1;
                    end
                    if (lastHit && phase == PH_COARSE) begin
                        phase <= PH_SCAN_C;
                    end else if (lastHit) begin
                        phase <= PH_SCAN_F;
                    end
                end
                PH_SCAN_C: begin
                    // fine pass opens the cycle after the coarse peak
                    if (peakValid) begin
                        phase <= PH_FINE;
                        absorbed <= '0;
                    end
                end
                PH_SCAN_F: begin
                    if (peakValid) begin
                        phase <= PH_DONE;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // read and write of a bin share one cycle
    // so back-to-back hits see the count just written
    always_ff @(posedge clk) begin
        if (clearHist) begin
            for (int i = 0; i < 16; i++) begin
                hist[i] <= '0;
            end
        end else if (bus.binValid && bus.inWindow && hist[bus.binAddr] != countMax) begin
            hist[bus.binAddr] <= hist[bus.binAddr] + 1'b1;
        end
    end

    // scan port for the peak finder
    assign scanCount = hist[scanAddr];

    // a full bin keeps its count
    assert property (@(posedge clk) disable iff (rst)
        (bus.binValid && bus.inWindow && !clearHist && hist[bus.binAddr] == countMax)
        |=> hist[$past(bus.binAddr)] == countMax);

    // no samples taken while scanning, idle or done
    assert property (@(posedge clk) disable iff (rst) !acquiring |-> !bus.ready);

    // folder's pass tag tracks our state
    assert property (@(posedge clk) disable iff (rst)
        bus.binValid |-> acquiring && (bus.phase == phase));

endmodule

// File: histBuilder/peakFinder.sv
module peakFinder import histPkg::*; #(
    parameter int countWidth = 8
) (
    input  logic  clk,
    input  logic  rst,
    input  phaseT phase,
    output binT   scanAddr,
    input  countT scanCount,
    output logic  peakValid,
    output binT   peakBin,
    output countT peakCount
);

    // phase one cycle back, for edge detect
    phaseT phaseQ;
    logic scanning;
    logic scanEntry;
    logic better;
    // running maximum
    logic [countWidth-1:0] best;

    // first cycle in either scan state
    assign scanEntry = (phase == PH_SCAN_C || phase == PH_SCAN_F) && (phase != phaseQ);

    // bin 0 seeds the max
    // strict compare so ties stay on the lowest bin
    assign better = (scanAddr == '0) || (scanCount[countWidth-1:0] > best);

    assign peakCount = countT'(best);

    always_ff @(posedge clk) begin
        if (rst) begin
            phaseQ <= PH_IDLE;
            scanning <= 1'b0;
            scanAddr <= '0;
            peakValid <= 1'b0;
            peakBin <= '0;
            best <= '0;
        end else begin
            phaseQ <= phase;
            peakValid <= 1'b0;
            if (scanEntry) begin
                scanning <= 1'b1;
                scanAddr <= '0;
            end else if (scanning) begin
                if (better) begin
                    best <= scanCount[countWidth-1:0];
                    peakBin <= scanAddr;
                end
                // 16 reads, then report
                if (scanAddr == 4'd15) begin
                    scanning <= 1'b0;
                    peakValid <= 1'b1;
                end else begin
                    scanAddr <= scanAddr + 1'b1;
                end
            end
        end
    end

    // single-cycle report
    assert property (@(posedge clk) disable iff (rst) peakValid |=> !peakValid);

    // builder still waiting in a scan state when the peak lands
    assert property (@(posedge clk) disable iff (rst)
        peakValid |-> (phase == PH_SCAN_C || phase == PH_SCAN_F));

endmodule

// File: rtl/apbRegs.sv
module apbRegs import histPkg::*, apbPkg::*; #(
    parameter int countWidth = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apbAddrT     paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    input  phaseT       phase,
    input  logic        peakValid,
    input  binT         peakBin,
    input  countT       peakCount,
    input  tsT          winBase,
    output logic        start,
    output nSampT       nSamp
);

    statusT status;
    logic access;
    logic wrEn;
    logic mapped;
    logic busy;
    logic doneFlag;
    logic coarsePeak;
    logic finePeak;
    binT coarseBin;
    countT coarseCount;
    binT fineBin;
    countT fineCount;
    tsT fineBase;
    tsT estimate;
    tsT estNext;

    // zero wait states, access phase completes the transfer
    assign access = psel && penable;
    assign wrEn = access && pwrite;

    // pending start pulse counts as busy
    assign busy = start || !(phase == PH_IDLE || phase == PH_DONE);
    assign status = {doneFlag, busy};

    // which peak this is follows from the phase
    assign coarsePeak = peakValid && (phase == PH_SCAN_C);
    assign finePeak = peakValid && (phase == PH_SCAN_F);

    // centre of the fine peak bin
    assign estNext = winBase + (tsT'(peakBin) << fineShift) + tsT'(fineHalf);

    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            nSamp <= nSampReset;
            doneFlag <= 1'b0;
            coarseBin <= '0;
            coarseCount <= '0;
            fineBin <= '0;
            fineCount <= '0;
            fineBase <= '0;
            estimate <= '0;
        end else begin
            start <= 1'b0;
            if (wrEn && paddr == REG_NSAMP) begin
                nSamp <= pwdata[11:0];
            end
            // start also wipes the previous run's results
            if (wrEn && paddr == REG_CTRL && pwdata[0] && !busy) begin
                start <= 1'b1;
                doneFlag <= 1'b0;
                coarseBin <= '0;
                coarseCount <= '0;
                fineBin <= '0;
                fineCount <= '0;
                fineBase <= '0;
                estimate <= '0;
            end else if (coarsePeak) begin
                coarseBin <= peakBin;
                coarseCount <= peakCount;
            end else if (finePeak) begin
                fineBin <= peakBin;
                fineCount <= peakCount;
                fineBase <= winBase;
                estimate <= estNext;
                doneFlag <= 1'b1;
            end
        end
    end

    // read mux, unknown offsets read zero and flag an error
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[0] = busy;
            end
            REG_NSAMP: begin
                prdata[11:0] = nSamp;
            end
            REG_STATUS: begin
                prdata[1:0] = status;
            end
            REG_COARSE: begin
                prdata[3:0] = coarseBin;
                prdata[8 +: countWidth] = coarseCount[countWidth-1:0];
            end
            REG_FINE: begin
                prdata[3:0] = fineBin;
                prdata[8 +: countWidth] = fineCount[countWidth-1:0];
                prdata[25:16] = fineBase;
            end
            REG_RESULT: begin
                prdata[9:0] = estimate;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    assign pslverr = access && !mapped;

    // done only once the builder has left the run
    assert property (@(posedge clk) disable iff (rst) !(doneFlag && busy));

endmodule

// File: rtl/histTop.sv
module histTop import histPkg::*, apbPkg::*; #(
    parameter int countWidth = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sampleValid,
    input  tsT          sampleData,
    output logic        sampleReady,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apbAddrT     paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr
);

    // folded events, folder to builder
    binBusIf binBus ();

    phaseT phase;
    // scan read port
    binT scanAddr;
    countT scanCount;
    // peak report, read by folder, builder and registers
    logic peakValid;
    binT peakBin;
    countT peakCount;
    tsT winBase;
    // control from software
    logic start;
    nSampT nSamp;

    // back-pressure comes straight from the builder
    assign sampleReady = binBus.ready;

    sampleFolder folderU0 (
        .clk(clk),
        .rst(rst),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .winBase(winBase),
        .bus(binBus.folder)
    );

    histBuilder #(.countWidth(countWidth)) builderU0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .nSamp(nSamp),
        .bus(binBus.builder),
        .scanAddr(scanAddr),
        .scanCount(scanCount),
        .peakValid(peakValid),
        .phase(phase)
    );

    peakFinder #(.countWidth(countWidth)) finderU0 (
        .clk(clk),
        .rst(rst),
        .phase(phase),
        .scanAddr(scanAddr),
        .scanCount(scanCount),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount)
    );

    apbRegs #(.countWidth(countWidth)) regsU0 (
        .clk(clk),
        .rst(rst),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pslverr(pslverr),
        .phase(phase),
        .peakValid(peakValid),
        .peakBin(peakBin),
        .peakCount(peakCount),
        .winBase(winBase),
        .start(start),
        .nSamp(nSamp)
    );

endmodule

// File: rtl/sampleFolder.sv
module sampleFolder import histPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    sampleValid,
    input  tsT      sampleData,
    input  logic    peakValid,
    input  binT     peakBin,
    output tsT      winBase,
    binBusIf.folder bus
);

    // pass that the next accepted sample belongs to
    phaseT passPhase;
    logic accept;
    tsT coarseEdge;
    tsT baseNext;
    tsT offset;
    logic fineHit;

    // handshake on the sample port
    assign accept = sampleValid && bus.ready;

    // lower edge of the coarse peak bin
    assign coarseEdge = tsT'(peakBin) << coarseShift;

    // pull the window below the edge, clamp to the code range
    always_comb begin
        if (coarseEdge < tsT'(winLead)) begin
            baseNext = '0;
        end else if (coarseEdge - tsT'(winLead) > tsT'(winMaxBase)) begin
            baseNext = tsT'(winMaxBase);
        end else begin
            baseNext = coarseEdge - tsT'(winLead);
        end
    end

    // offset into the window, wraps for codes below the base
    assign offset = sampleData - winBase;
    assign fineHit = (sampleData >= winBase) && (offset < tsT'(winSpan));

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.binValid <= 1'b0;
            bus.phase <= PH_IDLE;
            passPhase <= PH_COARSE;
            winBase <= '0;
        end else begin
            bus.binValid <= accept;
            if (accept) begin
                bus.phase <= passPhase;
            end
            // first peak of a run is the coarse one, second the fine one
            if (peakValid) begin
                if (passPhase == PH_COARSE) begin
                    winBase <= baseNext;
                    passPhase <= PH_FINE;
                end else begin
                    passPhase <= PH_COARSE;
                end
            end
        end
    end

    // event payload, qualified by binValid
    always_ff @(posedge clk) begin
        if (accept) begin
            if (passPhase == PH_COARSE) begin
                bus.binAddr <= binT'(sampleData >> coarseShift);
                bus.inWindow <= 1'b1;
            end else begin
                bus.binAddr <= binT'(offset >> fineShift);
                bus.inWindow <= fineHit;
            end
        end
    end

    // every bin event comes from a handshake one cycle before
    assert property (@(posedge clk) disable iff (rst) bus.binValid |-> $past(accept));

endmodule

// File: sim/histModel.svh
`ifndef HIST_MODEL_SVH
`define HIST_MODEL_SVH

// expected histograms, ints so the clip at full scale is explicit
int coarseExp [16];
int fineExp [16];
// mismatches over the whole run and inside the current test
int errCount;
int testErrs;

// counter full scale for the default 8-bit counters
localparam int satMax = (1 << $bits(countT)) - 1;

function automatic void clearModel();
    for (int i = 0; i < 16; i++) begin
        coarseExp[i] = 0;
        fineExp[i] = 0;
    end
endfunction

// coarse bin is the code divided by 64
function automatic void addCoarse(input tsT s);
    int b;
    b = int'(s) / 64;
    if (coarseExp[b] < satMax) begin
        coarseExp[b]++;
    end
endfunction

// counted either way, binned only inside the window
function automatic void addFine(input tsT s, input tsT base);
    int off;
    int b;
    off = int'(s) - int'(base);
    if (off >= 0 && off < winSpan) begin
        b = off >> fineShift;
        if (fineExp[b] < satMax) begin
            fineExp[b]++;
        end
    end
endfunction

// fullest bin, lowest index wins a tie
function automatic binT peakBinOf(input bit fine);
    int best;
    int cnt;
    int b;
    best = -1;
    b = 0;
    for (int i = 0; i < 16; i++) begin
        cnt = fine ? fineExp[i] : coarseExp[i];
        if (cnt > best) begin
            best = cnt;
            b = i;
        end
    end
    return binT'(b);
endfunction

function automatic countT peakCountOf(input bit fine);
    binT b;
    b = peakBinOf(fine);
    return countT'(fine ? fineExp[b] : coarseExp[b]);
endfunction

// window opens half a coarse bin below the peak bin, kept inside the code range
function automatic tsT baseFor(input binT b);
    int base;
    base = int'(b) * 64 - 32;
    if (base < 0) begin
        base = 0;
    end
    if (base > winMaxBase) begin
        base = winMaxBase;
    end
    return tsT'(base);
endfunction

// centre of the fine peak bin
function automatic tsT estimateFor(input tsT base, input binT b);
    return tsT'(int'(base) + int'(b) * 8 + 4);
endfunction

task automatic checkBin(input string name, input binT got, input binT exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        errCount++;
        testErrs++;
    end
endtask

task automatic checkCount(input string name, input countT got, input countT exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        errCount++;
        testErrs++;
    end
endtask

task automatic checkTs(input string name, input tsT got, input tsT exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        errCount++;
        testErrs++;
    end
endtask

task automatic checkNSamp(input string name, input nSampT got, input nSampT exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
        errCount++;
        testErrs++;
    end
endtask

task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        errCount++;
        testErrs++;
    end
endtask

`endif

// File: sim/histTb.sv
module histTb import histPkg::*, apbPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic clk;
    logic rst;
    logic sampleValid;
    tsT sampleData;
    logic sampleReady;
    logic psel;
    logic penable;
    logic pwrite;
    apbAddrT paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pslverr;

    `include "histModel.svh"

    int seed;
    // stimulus of one run, one array per pass
    tsT coarseS [512];
    tsT fineS [512];
    // last APB read
    logic [31:0] rdData;
    logic rdErr;
    bit timedOut;
    int testsRun;
    int testsFailed;

    histTop dut_i (
        .clk(clk),
        .rst(rst),
        .sampleValid(sampleValid),
        .sampleData(sampleData),
        .sampleReady(sampleReady),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // setup on one falling edge, access on the next, done at the rising edge between
    task automatic apbWrite(input apbAddrT addr, input logic [31:0] data);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbRead(input apbAddrT addr);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        @(negedge clk);
        penable = 1'b1;
        // read mux settled well before the rising edge
        #10;
        rdData = prdata;
        rdErr = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // 3 in 4 from the cluster, rest uniform over the code range
    function automatic tsT drawSample(input int center, input int spread, input bit noisy);
        int v;
        if (!noisy || $unsigned($random(seed)) % 4 != 0) begin
            v = center + int'($unsigned($random(seed)) % (2 * spread + 1)) - spread;
        end else begin
            v = int'($unsigned($random(seed)) % 1024);
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > 1023) begin
            v = 1023;
        end
        return tsT'(v);
    endfunction

    // called and returns on a falling edge, leaves valid high
    task automatic sendSample(input tsT data);
        int gap;
        int waited;
        if (timedOut) begin
            return;
        end
        gap = 0;
        if ($unsigned($random(seed)) % 4 == 0) begin
            gap = int'($unsigned($random(seed)) % 3) + 1;
        end
        if (gap > 0) begin
            sampleValid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        sampleValid = 1'b1;
        sampleData = data;
        // ready only depends on registers, stable here
        waited = 0;
        while (!sampleReady && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!sampleReady) begin
            $display("timeout: the DUT stopped accepting samples");
            timedOut = 1'b1;
            return;
        end
        // transfer happens on the rising edge in between
        @(negedge clk);
    endtask

    task automatic waitDone();
        int polls;
        polls = 0;
        rdData = '0;
        while (!rdData[1] && polls < 60 && !timedOut) begin
            apbRead(REG_STATUS);
            polls++;
        end
        if (!rdData[1] && !timedOut) begin
            $display("timeout: the run never reported done");
            timedOut = 1'b1;
        end
    endtask

    // start in the fine pass must be dropped
    // coarse results stay and fine ones remain cleared
    task automatic checkBusyStart(input binT cBin, input countT cCount);
        apbWrite(REG_CTRL, 32'h1);
        apbRead(REG_STATUS);
        checkFlag("STATUS.busy", rdData[0], 1'b1);
        checkFlag("STATUS.done", rdData[1], 1'b0);
        apbRead(REG_COARSE);
        checkBin("COARSE.bin", rdData[3:0], cBin);
        checkCount("COARSE.count", rdData[15:8], cCount);
        apbRead(REG_FINE);
        checkBin("FINE.bin", rdData[3:0], '0);
        checkCount("FINE.count", rdData[15:8], '0);
        checkTs("FINE.base", rdData[25:16], '0);
    endtask

    // one full run against the model
    task automatic runCluster(input int center, input int spread, input int n,
                              input bit noisy, input bit busyStart);
        tsT base;
        binT cBin;
        binT fBin;
        if (timedOut) begin
            return;
        end
        for (int i = 0; i < n; i++) begin
            coarseS[i] = drawSample(center, spread, noisy);
        end
        for (int i = 0; i < n; i++) begin
            fineS[i] = drawSample(center, spread, noisy);
        end
        clearModel();
        for (int i = 0; i < n; i++) begin
            addCoarse(coarseS[i]);
        end
        cBin = peakBinOf(1'b0);
        base = baseFor(cBin);
        for (int i = 0; i < n; i++) begin
            addFine(fineS[i], base);
        end
        fBin = peakBinOf(1'b1);
        apbWrite(REG_NSAMP, 32'(n));
        apbWrite(REG_CTRL, 32'h1);
        for (int i = 0; i < n; i++) begin
            sendSample(coarseS[i]);
        end
        // fine samples wait out the scan on ready
        for (int i = 0; i < n; i++) begin
            sendSample(fineS[i]);
            if (busyStart && i == n / 2 && !timedOut) begin
                sampleValid = 1'b0;
                checkBusyStart(cBin, peakCountOf(1'b0));
            end
        end
        sampleValid = 1'b0;
        waitDone();
        if (timedOut) begin
            return;
        end
        apbRead(REG_COARSE);
        checkBin("COARSE.bin", rdData[3:0], cBin);
        checkCount("COARSE.count", rdData[15:8], peakCountOf(1'b0));
        apbRead(REG_FINE);
        checkBin("FINE.bin", rdData[3:0], fBin);
        checkCount("FINE.count", rdData[15:8], peakCountOf(1'b1));
        checkTs("FINE.base", rdData[25:16], base);
        apbRead(REG_RESULT);
        checkTs("RESULT", rdData[9:0], estimateFor(base, fBin));
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrs == 0 && !timedOut) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d mismatches", name, testErrs);
        end
        testErrs = 0;
    endtask

    task automatic testRegisters();
        nSampT v;
        checkFlag("sampleReady", sampleReady, 1'b0);
        checkFlag("pslverr", pslverr, 1'b0);
        apbRead(REG_STATUS);
        checkFlag("STATUS.busy", rdData[0], 1'b0);
        checkFlag("STATUS.done", rdData[1], 1'b0);
        apbRead(REG_NSAMP);
        checkNSamp("NSAMP", rdData[11:0], 12'd64);
        checkFlag("pslverr", rdErr, 1'b0);
        for (int k = 0; k < 3; k++) begin
            v = nSampT'($random(seed));
            apbWrite(REG_NSAMP, 32'(v));
            apbRead(REG_NSAMP);
            checkNSamp("NSAMP", rdData[11:0], v);
        end
        // hole in the map
        apbRead(8'h18);
        checkFlag("pslverr", rdErr, 1'b1);
        checkFlag("prdata is zero", rdData == 32'h0, 1'b1);
        endTest("reset and registers");
    endtask

    task automatic testRandom();
        int center;
        int spread;
        int n;
        for (int r = 0; r < 4; r++) begin
            center = int'($unsigned($random(seed)) % 1024);
            spread = int'($unsigned($random(seed)) % 24) + 1;
            n = int'($unsigned($random(seed)) % 97) + 32;
            runCluster(center, spread, n, 1'b1, 1'b0);
        end
        endTest("random clusters");
    endtask

    task automatic testSaturation();
        runCluster(int'($unsigned($random(seed)) % 1024), 0, 400, 1'b0, 1'b0);
        if (!timedOut) begin
            apbRead(REG_COARSE);
            checkCount("COARSE.count", rdData[15:8], 8'd255);
        end
        endTest("saturation");
    endtask

    task automatic testBusyStart();
        logic seenReady;
        runCluster(int'($unsigned($random(seed)) % 1024), 10, 80, 1'b1, 1'b1);
        if (!timedOut) begin
            // offer samples while done, none may be taken
            seenReady = 1'b0;
            sampleValid = 1'b1;
            for (int i = 0; i < 20; i++) begin
                @(negedge clk);
                seenReady = seenReady | sampleReady;
            end
            sampleValid = 1'b0;
            checkFlag("sampleReady after done", seenReady, 1'b0);
            apbRead(REG_STATUS);
            checkFlag("STATUS.busy", rdData[0], 1'b0);
            checkFlag("STATUS.done", rdData[1], 1'b1);
        end
        // next start opens the port again
        runCluster(int'($unsigned($random(seed)) % 1024), 12, 48, 1'b1, 1'b0);
        endTest("start while busy");
    endtask

    initial begin
        seed = 32'h73f245eb;
        errCount = 0;
        testErrs = 0;
        testsRun = 0;
        testsFailed = 0;
        timedOut = 1'b0;
        rst = 1'b1;
        sampleValid = 1'b0;
        sampleData = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rdData = '0;
        rdErr = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        if (!timedOut) begin
            testRegisters();
        end
        if (!timedOut) begin
            testRandom();
        end
        // peaks in bin 0 and bin 15, base clamped at both ends
        if (!timedOut) begin
            runCluster(4, 6, 64, 1'b1, 1'b0);
            runCluster(1019, 6, 64, 1'b1, 1'b0);
            endTest("clamped windows");
        end
        if (!timedOut) begin
            testSaturation();
        end
        if (!timedOut) begin
            testBusyStart();
        end

        $display("%0d tests, %0d failed, %0d mismatches", testsRun, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0 && !timedOut) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
